// File: Bender.yml
package:
  name: div_pipe

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/div_types_pkg.sv
      - design/div_ctrl_pkg.sv
      - design/div_operand_prep.sv
      - design/div_stage.sv
      - design/div_nonrestoring_array.sv
      - design/div_result_fix.sv
      - design/div_pipe_top.sv
  - target: test
    files:
      - test/div_pipe_checker.sv
      - test/div_pipe_tb.sv

// File: design/div_cfg.svh
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

////////////////////////////////////////////////////////////
// Operand widths
////////////////////////////////////////////////////////////

`define DIV_DVD_W  8  // Dividend width
`define DIV_DVR_W  8  // Divisor width
`define DIV_FRAC_W 8  // Fraction bits of the quotient

////////////////////////////////////////////////////////////
// Derived widths
////////////////////////////////////////////////////////////

// One quotient bit per pipeline stage, so this is also the stage count
`define DIV_RES_W  (`DIV_DVD_W + `DIV_FRAC_W)
`define DIV_REM_W  (`DIV_DVR_W + 1)  // Extra bit holds the remainder sign

`endif

// File: design/div_ctrl_pkg.sv
`include "div_cfg.svh"

package div_ctrl_pkg;

  typedef enum logic {
    DIV_OP_UNSIGNED = 1'b0,  // Operands are plain magnitudes
    DIV_OP_SIGNED   = 1'b1   // Operands are two's complement
  } div_op_e;

  // Non-restoring step, picked from the incoming remainder sign
  typedef enum logic {
    STEP_SUB = 1'b0,  // Remainder non-negative
    STEP_ADD = 1'b1   // Remainder negative, restore by adding
  } div_step_e;

endpackage : div_ctrl_pkg

// File: design/div_nonrestoring_array.sv
`timescale 1ns/10ps
`include "div_cfg.svh"

module div_nonrestoring_array
  import div_types_pkg::*;
(
  input  logic i_div_a_clk_p,  // Rising edge clock
  input  logic q_div_s_rst_p,  // Sync reset, active high
  input  logic i_vld,          // Strobe from operand prep
  input  num_t i_num,          // Scaled dividend magnitude
  input  dvr_t i_dvr,          // Divisor magnitude
  input  logic i_neg,          // Result sign
  output logic o_vld,          // Strobe after the last stage
  output quo_t o_quo,          // Quotient magnitude
  output logic o_neg           // Sign aligned with o_quo
);

  localparam int STAGES = `DIV_RES_W;  // One quotient bit per stage

  ////////////////////////////////////////////////////////////
  // Inter-stage links, index i feeds stage i
  ////////////////////////////////////////////////////////////

  logic vld_s [0:STAGES];
  rem_t rem_s [0:STAGES];
  num_t num_s [0:STAGES];
  dvr_t dvr_s [0:STAGES];
  logic neg_s [0:STAGES];
  quo_t quo_s [0:STAGES];

  assign vld_s[0] = i_vld;
  assign rem_s[0] = '0;  // First step always subtracts
  assign num_s[0] = i_num;
  assign dvr_s[0] = i_dvr;
  assign neg_s[0] = i_neg;
  assign quo_s[0] = '0;  // Empty quotient

  ////////////////////////////////////////////////////////////
  // Stage chain
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < STAGES; i++) begin : g_stage
    div_stage u_stage (
      .i_div_a_clk_p (i_div_a_clk_p),
      .q_div_s_rst_p (q_div_s_rst_p),
      .i_vld         (vld_s[i]),
      .i_rem         (rem_s[i]),
      .i_num         (num_s[i]),
      .i_dvr         (dvr_s[i]),
      .i_neg         (neg_s[i]),
      .i_quo         (quo_s[i]),
      .o_vld         (vld_s[i+1]),
      .o_rem         (rem_s[i+1]),  // Last one is the final remainder, not needed
      .o_num         (num_s[i+1]),
      .o_dvr         (dvr_s[i+1]),
      .o_neg         (neg_s[i+1]),
      .o_quo         (quo_s[i+1])
    );
  end : g_stage

  assign o_vld = vld_s[STAGES];
  assign o_quo = quo_s[STAGES];
  assign o_neg = neg_s[STAGES];

endmodule : div_nonrestoring_array

// File: design/div_operand_prep.sv
`timescale 1ns/10ps

module div_operand_prep
  import div_types_pkg::*;
  import div_ctrl_pkg::*;
(
  input  logic    i_div_a_clk_p,  // Rising edge clock
  input  logic    q_div_s_rst_p,  // Sync reset, active high
  input  logic    i_vld,          // Operand strobe
  input  div_op_e i_op,           // Signed or unsigned
  input  dvd_t    i_dvd,          // Raw dividend
  input  dvr_t    i_dvr,          // Raw divisor
  output logic    o_vld,          // Strobe, one cycle later
  output num_t    o_num,          // Dividend magnitude, fraction appended
  output dvr_t    o_dvr,          // Divisor magnitude
  output logic    o_neg           // Result must be negated
);

  logic is_signed;  // Sign bits only count in signed mode
  logic dvd_sgn;
  logic dvr_sgn;
  dvd_t dvd_mag;
  dvr_t dvr_mag;

  assign is_signed = (i_op == DIV_OP_SIGNED);
  assign dvd_sgn   = is_signed & i_dvd[$high(i_dvd)];  // Negative dividend
  assign dvr_sgn   = is_signed & i_dvr[$high(i_dvr)];  // Negative divisor

  // -128 maps onto 128, which still fits the unsigned magnitude
  assign dvd_mag = dvd_sgn ? dvd_t'(~i_dvd + 1'b1) : i_dvd;
  assign dvr_mag = dvr_sgn ? dvr_t'(~i_dvr + 1'b1) : i_dvr;

  always_ff @(posedge i_div_a_clk_p) begin
    if (q_div_s_rst_p) begin
      o_vld <= 1'b0;  // Drop anything in flight
    end else begin
      o_vld <= i_vld;
    end
  end

  always_ff @(posedge i_div_a_clk_p) begin
    o_num <= num_t'(dvd_mag) << ($bits(num_t) - $bits(dvd_t));  // Scale by 2^FRAC
    o_dvr <= dvr_mag;
    o_neg <= dvd_sgn ^ dvr_sgn;  // Exactly one operand negative
  end

endmodule : div_operand_prep

// File: design/div_pipe_top.sv
`timescale 1ns/10ps

module div_pipe_top
  import div_types_pkg::*;
  import div_ctrl_pkg::*;
(
  input  logic    i_div_a_clk_p,  // Rising edge clock
  input  logic    q_div_s_rst_p,  // Sync reset, active high
  input  logic    i_vld,          // Operand strobe, any cycle
  input  div_op_e i_op,           // Per transaction signedness
  input  dvd_t    i_dvd,          // Dividend
  input  dvr_t    i_dvr,          // Divisor
  output logic    o_res_vld,      // Strobe, 18 cycles after i_vld
  output quo_t    o_res           // Quotient, 8 fraction bits
);

  ////////////////////////////////////////////////////////////
  // Prep to array
  ////////////////////////////////////////////////////////////

  logic prep_vld;
  num_t prep_num;
  dvr_t prep_dvr;
  logic prep_neg;

  ////////////////////////////////////////////////////////////
  // Array to fix
  ////////////////////////////////////////////////////////////

  logic arr_vld;
  quo_t arr_quo;
  logic arr_neg;

  div_operand_prep u_prep (
    .i_div_a_clk_p (i_div_a_clk_p),
    .q_div_s_rst_p (q_div_s_rst_p),
    .i_vld         (i_vld),
    .i_op          (i_op),
    .i_dvd         (i_dvd),
    .i_dvr         (i_dvr),
    .o_vld         (prep_vld),
    .o_num         (prep_num),
    .o_dvr         (prep_dvr),
    .o_neg         (prep_neg)
  );

  div_nonrestoring_array u_array (
    .i_div_a_clk_p (i_div_a_clk_p),
    .q_div_s_rst_p (q_div_s_rst_p),
    .i_vld         (prep_vld),
    .i_num         (prep_num),
    .i_dvr         (prep_dvr),
    .i_neg         (prep_neg),
    .o_vld         (arr_vld),
    .o_quo         (arr_quo),
    .o_neg         (arr_neg)
  );

  div_result_fix u_fix (
    .i_div_a_clk_p (i_div_a_clk_p),
    .q_div_s_rst_p (q_div_s_rst_p),
    .i_vld         (arr_vld),
    .i_quo         (arr_quo),
    .i_neg         (arr_neg),
    .o_res_vld     (o_res_vld),
    .o_res         (o_res)
  );

endmodule : div_pipe_top

// File: design/div_result_fix.sv
`timescale 1ns/10ps

module div_result_fix
  import div_types_pkg::*;
(
  input  logic i_div_a_clk_p,  // Rising edge clock
  input  logic q_div_s_rst_p,  // Sync reset, active high
  input  logic i_vld,          // Strobe from the array
  input  quo_t i_quo,          // Quotient magnitude
  input  logic i_neg,          // Negate the result
  output logic o_res_vld,      // Result strobe
  output quo_t o_res           // Final quotient, modulo 2^16
);

  quo_t res_nxt;

  // Two's complement, so a saturated FFFF becomes 0001
  assign res_nxt = i_neg ? quo_t'(~i_quo + 1'b1) : i_quo;

  always_ff @(posedge i_div_a_clk_p) begin
    if (q_div_s_rst_p) begin
      o_res_vld <= 1'b0;
    end else begin
      o_res_vld <= i_vld;
    end
  end

  always_ff @(posedge i_div_a_clk_p) begin
    o_res <= res_nxt;  // Only meaningful with o_res_vld
  end

endmodule : div_result_fix

// File: design/div_stage.sv
`timescale 1ns/10ps

module div_stage
  import div_types_pkg::*;
  import div_ctrl_pkg::*;
(
  input  logic i_div_a_clk_p,  // Rising edge clock
  input  logic q_div_s_rst_p,  // Sync reset, active high
  input  logic i_vld,          // Valid from previous stage
  input  rem_t i_rem,          // Partial remainder
  input  num_t i_num,          // Numerator bits still to consume
  input  dvr_t i_dvr,          // Divisor magnitude
  input  logic i_neg,          // Result sign, carried along
  input  quo_t i_quo,          // Quotient bits so far
  output logic o_vld,
  output rem_t o_rem,
  output num_t o_num,
  output dvr_t o_dvr,
  output logic o_neg,
  output quo_t o_quo
);

  div_step_e step;
  rem_t      rem_sh;   // Remainder with next numerator bit shifted in
  rem_t      dvr_ext;  // Divisor widened to remainder width
  rem_t      rem_nxt;
  logic      dvr_zero;
  logic      quo_bit;

  assign step    = i_rem[$high(i_rem)] ? STEP_ADD : STEP_SUB;  // Negative remainder adds
  assign rem_sh  = {i_rem[$high(i_rem)-1:0], i_num[$high(i_num)]};
  assign dvr_ext = {1'b0, i_dvr};
  // Shifted value may wrap, the sum lands back in range
  assign rem_nxt = (step == STEP_ADD) ? rem_sh + dvr_ext : rem_sh - dvr_ext;

  // Zero divisor saturates the quotient to all ones
  assign dvr_zero = (i_dvr == '0);
  assign quo_bit  = ~rem_nxt[$high(rem_nxt)] | dvr_zero;  // One when remainder >= 0

  always_ff @(posedge i_div_a_clk_p) begin
    if (q_div_s_rst_p) begin
      o_vld <= 1'b0;
    end else begin
      o_vld <= i_vld;
    end
  end

  always_ff @(posedge i_div_a_clk_p) begin
    o_rem <= rem_nxt;
    o_num <= num_t'(i_num << 1);  // Next bit to the top
    o_dvr <= i_dvr;
    o_neg <= i_neg;
    o_quo <= {i_quo[$high(i_quo)-1:0], quo_bit};  // MSB first
  end

endmodule : div_stage

// File: design/div_types_pkg.sv
`include "div_cfg.svh"

package div_types_pkg;

  ////////////////////////////////////////////////////////////
  // Operand types
  ////////////////////////////////////////////////////////////

  typedef logic [`DIV_DVD_W-1:0] dvd_t;  // Dividend, raw or magnitude
  typedef logic [`DIV_DVR_W-1:0] dvr_t;  // Divisor, raw or magnitude

  ////////////////////////////////////////////////////////////
  // Array types
  ////////////////////////////////////////////////////////////

  // Dividend magnitude with fraction zeros below, consumed MSB first
  typedef logic [`DIV_RES_W-1:0] num_t;

  // Partial remainder, may go negative between steps
  typedef logic signed [`DIV_REM_W-1:0] rem_t;

  typedef logic [`DIV_RES_W-1:0] quo_t;  // Quotient, 8 fraction bits

endpackage : div_types_pkg

// File: div_pipe_top.f
+incdir+design
design/div_types_pkg.sv
design/div_ctrl_pkg.sv
design/div_operand_prep.sv
design/div_stage.sv
design/div_nonrestoring_array.sv
design/div_result_fix.sv
design/div_pipe_top.sv
test/div_pipe_checker.sv
test/div_pipe_tb.sv

// File: test/div_pipe_checker.sv
`timescale 1ns/10ps

module div_pipe_checker
  import div_types_pkg::*;
  import div_ctrl_pkg::*;
(
  input  logic    i_div_a_clk_p,  // Same clock as the DUT
  input  logic    q_div_s_rst_p,  // DUT reset, flushes the queue
  input  logic    i_vld,          // DUT operand strobe
  input  div_op_e i_op,
  input  dvd_t    i_dvd,
  input  dvr_t    i_dvr,
  input  logic    i_exp_use,      // Table row, take i_exp_val as is
  input  quo_t    i_exp_val,
  input  logic    i_res_vld,      // DUT result strobe
  input  quo_t    i_res,
  output int      o_pend,         // Results still in flight
  output int      o_checks,
  output int      o_errors
);

  localparam int LATENCY = 18;  // i_vld to o_res_vld, in cycles

  quo_t want_q[$];  // Expected results, oldest first
  int   cyc_q[$];   // Cycle of each strobe
  int   cyc = 0;
  int   n_pend = 0;
  int   n_checks = 0;
  int   n_errors = 0;
  logic rst_d = 1'b0;  // Reset seen on the previous edge
  quo_t want;
  int   start;

  assign o_pend   = n_pend;
  assign o_checks = n_checks;
  assign o_errors = n_errors;

  // Q = floor(|dvd| * 256 / |dvr|), sign applied afterwards, modulo 2^16
  function automatic quo_t expect_quotient(div_op_e op, dvd_t dvd, dvr_t dvr);
    int a;
    int b;
    int q;
    if (op == DIV_OP_SIGNED) begin
      a = $signed(dvd);
      b = $signed(dvr);
    end else begin
      a = dvd;  // Raw values are the magnitudes
      b = dvr;
    end
    if (b == 0) q = 65535;  // Saturated magnitude
    else q = ((a < 0) ? -a : a) * 256 / ((b < 0) ? -b : b);
    if ((a < 0) != (b < 0)) q = -q;  // Exactly one operand negative
    return quo_t'(q);
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare on every rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge i_div_a_clk_p) begin
    cyc = cyc + 1;
    if (q_div_s_rst_p) begin
      if (rst_d && i_res_vld) begin
        $display("Result strobe seen while reset was held, at %0t", $time);
        n_errors++;
      end
      want_q.delete();  // Items in flight are lost
      cyc_q.delete();
    end else begin
      if (i_res_vld) begin
        if (want_q.size() == 0) begin
          $display("Result strobe at %0t with no operand in flight", $time);
          n_errors++;
        end else begin
          want  = want_q.pop_front();
          start = cyc_q.pop_front();
          n_checks++;
          if (i_res !== want) begin
            $display("** Error at %0t: result %h, expected %h", $time, i_res, want);
            n_errors++;
          end
          if (cyc - start != LATENCY) begin
            $display("** Error at %0t: latency %0d cycles, expected %0d", $time,
                     cyc - start, LATENCY);
            n_errors++;
          end
        end
      end
      if (i_vld) begin
        want_q.push_back(i_exp_use ? i_exp_val : expect_quotient(i_op, i_dvd, i_dvr));
        cyc_q.push_back(cyc);
      end
    end
    rst_d  = q_div_s_rst_p;
    n_pend = want_q.size();
  end

endmodule : div_pipe_checker

// File: test/div_pipe_tb.sv
`timescale 1ns/10ps

module div_pipe_tb
  import div_types_pkg::*;
  import div_ctrl_pkg::*;
();

  localparam int DRAIN_MAX = 40;  // Cycles allowed for the pipe to empty

  typedef struct packed {
    logic [1:0] grp;  // Test the row belongs to
    div_op_e    op;
    dvd_t       dvd;
    dvr_t       dvr;
    quo_t       exp;
  } row_t;

  logic    i_div_a_clk_p;
  logic    q_div_s_rst_p;
  logic    i_vld;
  div_op_e i_op;
  dvd_t    i_dvd;
  dvr_t    i_dvr;
  logic    o_res_vld;
  quo_t    o_res;
  logic    exp_use;   // Expected value comes with the strobe
  quo_t    exp_val;
  int      pend;
  int      checks;
  int      errors;
  int      tb_fails;  // Timeouts and other non-compare failures
  int      seed;
  int      chk_base;
  int      err_base;
  row_t    rows[$];

  ////////////////////////////////////////////////////////////
  // Clock, DUT and checker
  ////////////////////////////////////////////////////////////

  initial begin
    i_div_a_clk_p = 1'b0;
    forever #50 i_div_a_clk_p = ~i_div_a_clk_p;  // 100 ns period
  end

  div_pipe_top DUT (
    .i_div_a_clk_p (i_div_a_clk_p),
    .q_div_s_rst_p (q_div_s_rst_p),
    .i_vld         (i_vld),
    .i_op          (i_op),
    .i_dvd         (i_dvd),
    .i_dvr         (i_dvr),
    .o_res_vld     (o_res_vld),
    .o_res         (o_res)
  );

  div_pipe_checker u_checker (
    .i_div_a_clk_p (i_div_a_clk_p),
    .q_div_s_rst_p (q_div_s_rst_p),
    .i_vld         (i_vld),
    .i_op          (i_op),
    .i_dvd         (i_dvd),
    .i_dvr         (i_dvr),
    .i_exp_use     (exp_use),
    .i_exp_val     (exp_val),
    .i_res_vld     (o_res_vld),
    .i_res         (o_res),
    .o_pend        (pend),
    .o_checks      (checks),
    .o_errors      (errors)
  );

  task automatic add_row(input logic [1:0] grp, input div_op_e op, input dvd_t dvd,
                         input dvr_t dvr, input quo_t exp);
    rows.push_back(row_t'({grp, op, dvd, dvr, exp}));
  endtask

  task automatic load_table();
    add_row(2'd1, DIV_OP_UNSIGNED, 8'd3,   8'd2,   16'h0180);
    add_row(2'd1, DIV_OP_UNSIGNED, 8'd255, 8'd1,   16'hFF00);
    add_row(2'd1, DIV_OP_UNSIGNED, 8'd1,   8'd3,   16'h0055);  // 85.33 floors
    add_row(2'd1, DIV_OP_UNSIGNED, 8'd200, 8'd7,   16'h1C92);
    add_row(2'd1, DIV_OP_UNSIGNED, 8'd128, 8'd200, 16'h00A3);  // MSB set but unsigned
    add_row(2'd2, DIV_OP_SIGNED,   8'h06,  8'h03,  16'h0200);  // 6 / 3
    add_row(2'd2, DIV_OP_SIGNED,   8'hFA,  8'h03,  16'hFE00);  // -6 / 3
    add_row(2'd2, DIV_OP_SIGNED,   8'h06,  8'hFD,  16'hFE00);  // 6 / -3
    add_row(2'd2, DIV_OP_SIGNED,   8'hFA,  8'hFD,  16'h0200);  // -6 / -3
    add_row(2'd2, DIV_OP_SIGNED,   8'h80,  8'hFF,  16'h8000);  // -128 / -1 wraps
    add_row(2'd2, DIV_OP_SIGNED,   8'h01,  8'hFD,  16'hFFAB);  // -85
    add_row(2'd3, DIV_OP_UNSIGNED, 8'd9,   8'd0,   16'hFFFF);
    add_row(2'd3, DIV_OP_SIGNED,   8'h05,  8'h00,  16'hFFFF);
    add_row(2'd3, DIV_OP_SIGNED,   8'hFB,  8'h00,  16'h0001);  // Negated saturation
  endtask

  task automatic drive_row(input row_t r);
    @(negedge i_div_a_clk_p);
    i_vld   = 1'b1;
    i_op    = r.op;
    i_dvd   = r.dvd;
    i_dvr   = r.dvr;
    exp_use = 1'b1;
    exp_val = r.exp;
  endtask

  task automatic drive_random();
    int r;
    @(negedge i_div_a_clk_p);
    r       = $random(seed);
    i_vld   = 1'b1;
    i_op    = r[0] ? DIV_OP_SIGNED : DIV_OP_UNSIGNED;  // Mixed opcodes
    i_dvd   = r[15:8];
    i_dvr   = r[23:16];
    exp_use = 1'b0;  // Checker computes the expected quotient
  endtask

  task automatic set_idle();
    @(negedge i_div_a_clk_p);
    i_vld   = 1'b0;
    exp_use = 1'b0;
  endtask

  // Waits for the checker queue to empty, then reports the test
  task automatic end_test(input string name);
    int n;
    n = 0;
    while (pend != 0 && n < DRAIN_MAX) begin
      @(negedge i_div_a_clk_p);
      n++;
    end
    if (pend != 0) begin
      $display("Timeout in %s: %0d results still pending after %0d cycles", name, pend, n);
      tb_fails++;
    end
    $display("Test %s: %0d checks, %0d errors", name, checks - chk_base, errors - err_base);
    chk_base = checks;
    err_base = errors;
  endtask

  task automatic run_group(input logic [1:0] grp, input string name);
    foreach (rows[i]) begin
      if (rows[i].grp == grp) drive_row(rows[i]);
    end
    set_idle();
    end_test(name);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed          = 49;
    tb_fails      = 0;
    chk_base      = 0;
    err_base      = 0;
    q_div_s_rst_p = 1'b1;
    i_vld         = 1'b0;
    i_op          = DIV_OP_UNSIGNED;
    i_dvd         = '0;
    i_dvr         = '0;
    exp_use       = 1'b0;
    exp_val       = '0;
    load_table();
    repeat (8) @(negedge i_div_a_clk_p);  // 8 reset cycles
    q_div_s_rst_p = 1'b0;

    run_group(2'd1, "unsigned directed");
    run_group(2'd2, "signed directed");
    run_group(2'd3, "zero divisor");

    repeat (40) drive_random();  // Strobe on every cycle
    set_idle();
    end_test("back to back");

    repeat (10) drive_random();
    @(negedge i_div_a_clk_p);
    i_vld         = 1'b0;
    q_div_s_rst_p = 1'b1;  // Hit the pipe with items in flight
    repeat (3) @(negedge i_div_a_clk_p);
    q_div_s_rst_p = 1'b0;
    repeat (24) @(negedge i_div_a_clk_p);  // Any stray strobe is flagged here
    repeat (5) drive_random();
    set_idle();
    end_test("reset in flight");

    repeat (200) drive_random();
    set_idle();
    end_test("random");

    $display("Summary: %0d checks, %0d errors, %0d other failures", checks, errors, tb_fails);
    if (errors == 0 && tb_fails == 0 && checks > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : div_pipe_tb
